// File: csr_file.f
csr_types_pkg.sv
csr_addr_pkg.sv
csr_access_decode.sv
machine_csr_regs.sv
perf_counter.sv
csr_read_mux.sv
csr_file.sv
csr_file_assert.sv
csr_file_monitor.sv
tb_csr_file.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CSR file testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_csr_file -f csr_file.f \
  && ./obj_dir/Vtb_csr_file +verilator+error+limit+1000 | tee /dev/stderr \
     | grep -qx "Regression passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// File: tb_csr_file.sv
// Testbench for the machine-mode CSR file
// Seeded random accesses in six test phases, checked by the monitor
`timescale 1ns/1ps

module tb_csr_file
  import csr_types_pkg::*, csr_addr_pkg::*;
();

  localparam int          HART           = 5;
  localparam logic [31:0] SEED           = 32'h3b6e8fa9;
  localparam int          LEN_RESET      = 25;   // One read per kept address
  localparam int          LEN_RAND       = 300;
  localparam int          TIMEOUT_CYCLES = LEN_RESET + 5 * LEN_RAND + 100;

  localparam logic [11:0] KEPT_ADDRS [25] = '{
    MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR, MCONFIGPTR_ADDR,
    MSTATUS_ADDR, MISA_ADDR, MIE_ADDR, MTVEC_ADDR, MCOUNTEREN_ADDR,
    MSTATUSH_ADDR, MCOUNTINHIBIT_ADDR, MSCRATCH_ADDR, MEPC_ADDR, MCAUSE_ADDR,
    MTVAL_ADDR, MIP_ADDR, MCYCLE_ADDR, MINSTRET_ADDR, MCYCLEH_ADDR,
    MINSTRETH_ADDR, CYCLE_ADDR, INSTRET_ADDR, CYCLEH_ADDR, INSTRETH_ADDR
  };
  localparam logic [11:0] RW_ADDRS [4]    = '{MSCRATCH_ADDR, MEPC_ADDR, MTVAL_ADDR, MCAUSE_ADDR};
  localparam logic [11:0] LEGAL_ADDRS [4] = '{MSTATUS_ADDR, MTVEC_ADDR, MIE_ADDR, MIP_ADDR};
  localparam logic [11:0] TRAP_ADDRS [5]  = '{
    MSTATUS_ADDR, MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR, MIP_ADDR
  };
  localparam logic [11:0] COUNTER_ADDRS [10] = '{
    MCYCLE_ADDR, MCYCLEH_ADDR, MINSTRET_ADDR, MINSTRETH_ADDR, MCOUNTINHIBIT_ADDR,
    MCOUNTEREN_ADDR, CYCLE_ADDR, CYCLEH_ADDR, INSTRET_ADDR, INSTRETH_ADDR
  };

  logic         CLK;
  logic         nRST;
  csr_req_t     req;
  trap_inject_t inject;
  logic         inst_ret;
  csr_word_t    rdata;
  logic         invalid;
  trap_state_t  trap_state;
  logic [2:0]   test_id;
  int           checks, rdata_errors, invalid_errors, state_errors;
  int           errors;
  int           cycle_count = 0;

  csr_file #(
    .HART_ID(HART)
  ) i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .inject    (inject),
    .inst_ret  (inst_ret),
    .rdata     (rdata),
    .invalid   (invalid),
    .trap_state(trap_state)
  );

  csr_file_monitor #(
    .HART_ID(HART)
  ) u_monitor (
    .CLK           (CLK),
    .nRST          (nRST),
    .req           (req),
    .inject        (inject),
    .inst_ret      (inst_ret),
    .rdata         (rdata),
    .invalid       (invalid),
    .trap_state    (trap_state),
    .test_id       (test_id),
    .checks        (checks),
    .rdata_errors  (rdata_errors),
    .invalid_errors(invalid_errors),
    .state_errors  (state_errors)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic flip_coin();
    return $urandom_range(1, 0) != 0;
  endfunction

  function automatic int pick_index(int n);
    return int'($urandom_range(n - 1, 0));
  endfunction

  // One access per cycle, shaped by the current test
  task automatic make_access(input logic [2:0] id, input int k);
    req.op          = csr_op_t'(2'($urandom_range(3, 0)));
    req.wdata       = $urandom;
    req.valid_write = ($urandom_range(7, 0) != 0);
    req.priv        = M_MODE;
    inject          = '0;
    inst_ret        = flip_coin();
    case (id)
      3'd1: begin
        req.addr = KEPT_ADDRS[k];
        req.op   = CSR_NONE;
      end
      3'd2: req.addr = RW_ADDRS[pick_index(4)];
      3'd3: req.addr = LEGAL_ADDRS[pick_index(4)];
      3'd4: begin
        req.priv = flip_coin() ? U_MODE : M_MODE;
        req.addr = flip_coin() ? KEPT_ADDRS[pick_index(25)] : 12'($urandom);
      end
      3'd5: begin
        req.addr = COUNTER_ADDRS[pick_index(10)];
        if (req.addr[11:10] == 2'b11) begin   // User shadows, mostly plain reads
          req.priv = flip_coin() ? U_MODE : M_MODE;
          if (pick_index(4) != 0) req.op = CSR_NONE;
        end
      end
      default: begin
        req.addr          = TRAP_ADDRS[pick_index(5)];
        inject.mstatus_en = flip_coin();
        inject.mstatus    = mstatus_t'($urandom);
        inject.mepc_en    = flip_coin();
        inject.mepc       = $urandom;
        inject.mcause_en  = flip_coin();
        inject.mcause     = mcause_t'($urandom);
        inject.mtval_en   = flip_coin();
        inject.mtval      = $urandom;
        inject.mip_en     = flip_coin();
        inject.mip        = mip_t'($urandom);
      end
    endcase
  endtask

  task automatic run_test(input logic [2:0] id, input int len);
    for (int k = 0; k < len; k++) begin
      @(posedge CLK);
      #2;
      test_id = id;
      make_access(id, k);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    nRST     = 1'b0;
    req      = '0;
    req.priv = M_MODE;
    inject   = '0;
    inst_ret = 1'b0;
    test_id  = 3'd0;
    @(posedge CLK);
    #2;
    req.addr = CYCLE_ADDR;   // U-mode counter read while reset is held
    req.priv = U_MODE;
    @(posedge CLK);
    #2 nRST = 1'b1;

    run_test(3'd1, LEN_RESET);
    run_test(3'd2, LEN_RAND);
    run_test(3'd3, LEN_RAND);
    run_test(3'd4, LEN_RAND);
    run_test(3'd5, LEN_RAND);
    run_test(3'd6, LEN_RAND);

    @(negedge CLK);   // Last access compared here
    #1;
    errors = rdata_errors + invalid_errors + state_errors + i_dut.u_checks.fail_count;
    $display("Checks %0d, rdata errors %0d, invalid errors %0d, state errors %0d, %s %0d",
             checks, rdata_errors, invalid_errors, state_errors,
             "assertion failures", i_dut.u_checks.fail_count);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: csr_file_monitor.sv
// Reference model of the machine-mode CSR file
// Tracks every kept CSR and both counters, and checks rdata, invalid
// and trap_state at each falling clock edge
`timescale 1ns/1ps

module csr_file_monitor
  import csr_types_pkg::*, csr_addr_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic         CLK,
  input  logic         nRST,
  input  csr_req_t     req,
  input  trap_inject_t inject,
  input  logic         inst_ret,
  input  csr_word_t    rdata,
  input  logic         invalid,
  input  trap_state_t  trap_state,
  input  logic [2:0]   test_id,
  output int           checks,
  output int           rdata_errors,
  output int           invalid_errors,
  output int           state_errors
);

  localparam csr_word_t STATUS_FIELDS = 32'h0022_1888;  // mie, mpie, mpp, mprv, tw
  localparam csr_word_t IRQ_BITS      = 32'h0000_0888;  // msi, mti, mei

  csr_word_t m_status, m_tvec, m_ie, m_ip;
  csr_word_t m_cause, m_epc, m_scratch, m_tval;
  csr_word_t m_counteren, m_inhibit;
  dword_t    m_cycle, m_instret;

  int n_checks = 0;
  int n_rdata  = 0;
  int n_inv    = 0;
  int n_state  = 0;

  assign checks         = n_checks;
  assign rdata_errors   = n_rdata;
  assign invalid_errors = n_inv;
  assign state_errors   = n_state;

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd1:    return "reset";
      3'd2:    return "write_set_clear";
      3'd3:    return "legal_values";
      3'd4:    return "priv_faults";
      3'd5:    return "counters";
      3'd6:    return "trap_inject";
      default: return "idle";
    endcase
  endfunction

  function automatic csr_word_t legal_status(csr_word_t v);
    csr_word_t r;
    r = v & STATUS_FIELDS;
    if (v[12:11] != 2'b11) r[12:11] = 2'b00;  // S and reserved fall back to U
    return r;
  endfunction

  // Expected old value and invalid flag for one access
  function automatic void model_read(input logic [11:0] a, input logic [1:0] priv,
                                     input logic has_op, output csr_word_t val,
                                     output logic inv);
    logic user_cy;
    logic user_ir;
    user_cy = (priv == 2'b00) && !m_counteren[0];
    user_ir = (priv == 2'b00) && !m_counteren[2];
    val     = '0;
    inv     = 1'b0;
    case (a)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR,
      MCONFIGPTR_ADDR, MSTATUSH_ADDR: val = '0;
      MHARTID_ADDR:       val = csr_word_t'(HART_ID);
      MISA_ADDR:          val = MISA_VALUE;
      MSTATUS_ADDR:       val = m_status;
      MTVEC_ADDR:         val = m_tvec;
      MIE_ADDR:           val = m_ie;
      MIP_ADDR:           val = m_ip;
      MSCRATCH_ADDR:      val = m_scratch;
      MEPC_ADDR:          val = m_epc;
      MCAUSE_ADDR:        val = m_cause;
      MTVAL_ADDR:         val = m_tval;
      MCOUNTEREN_ADDR:    val = m_counteren;
      MCOUNTINHIBIT_ADDR: val = m_inhibit;
      MCYCLE_ADDR:        val = m_cycle[31:0];
      MCYCLEH_ADDR:       val = m_cycle[63:32];
      MINSTRET_ADDR:      val = m_instret[31:0];
      MINSTRETH_ADDR:     val = m_instret[63:32];
      CYCLE_ADDR:         val = user_cy ? '0 : m_cycle[31:0];
      CYCLEH_ADDR:        val = user_cy ? '0 : m_cycle[63:32];
      INSTRET_ADDR:       val = user_ir ? '0 : m_instret[31:0];
      INSTRETH_ADDR:      val = user_ir ? '0 : m_instret[63:32];
      default:            inv = has_op;   // Unknown address
    endcase
    if ((a == CYCLE_ADDR || a == CYCLEH_ADDR) && user_cy) inv = 1'b1;
    if ((a == INSTRET_ADDR || a == INSTRETH_ADDR) && user_ir) inv = 1'b1;
    // Read-only space or a level above the current one
    if (has_op && (a[11:10] == 2'b11 || a[9:8] > priv)) inv = 1'b1;
  endfunction

  always @(posedge CLK or negedge nRST) begin : model_update
    csr_word_t old_v;
    csr_word_t new_v;
    logic      fault;
    dword_t    cy_next;
    dword_t    ir_next;
    if (!nRST) begin
      m_status    = MSTATUS_RESET;
      m_tvec      = '0;
      m_ie        = '0;
      m_ip        = '0;
      m_cause     = '0;
      m_epc       = '0;
      m_scratch   = '0;
      m_tval      = '0;
      m_counteren = MCOUNTEREN_RESET;
      m_inhibit   = '0;
      m_cycle     = '0;
      m_instret   = '0;
    end else begin
      model_read(req.addr, req.priv, req.op != CSR_NONE, old_v, fault);
      case (req.op)
        CSR_SET:   new_v = old_v | req.wdata;
        CSR_CLEAR: new_v = old_v & ~req.wdata;
        default:   new_v = req.wdata;
      endcase
      // Increment uses the inhibit value before this cycle's write
      cy_next = m_inhibit[0] ? m_cycle : m_cycle + 64'd1;
      ir_next = m_inhibit[2] ? m_instret : m_instret + 64'(inst_ret);
      if (req.op != CSR_NONE && req.valid_write && !fault) begin
        case (req.addr)
          MSTATUS_ADDR:       m_status = legal_status(new_v);
          MTVEC_ADDR:         m_tvec = (new_v[1:0] > 2'b01) ? {new_v[31:2], 2'b00} : new_v;
          MIE_ADDR:           m_ie = new_v & IRQ_BITS;
          MIP_ADDR:           m_ip = new_v & IRQ_BITS;
          MSCRATCH_ADDR:      m_scratch = new_v;
          MEPC_ADDR:          m_epc = new_v;
          MCAUSE_ADDR:        m_cause = new_v;
          MTVAL_ADDR:         m_tval = new_v;
          MCOUNTEREN_ADDR:    m_counteren = new_v;
          MCOUNTINHIBIT_ADDR: m_inhibit = new_v;
          // A half write skips the increment and keeps the other half
          MCYCLE_ADDR:        cy_next = {m_cycle[63:32], new_v};
          MCYCLEH_ADDR:       cy_next = {new_v, m_cycle[31:0]};
          MINSTRET_ADDR:      ir_next = {m_instret[63:32], new_v};
          MINSTRETH_ADDR:     ir_next = {new_v, m_instret[31:0]};
          default:            ;
        endcase
      end
      // Trap controller beats a same-cycle CSR write
      if (inject.mstatus_en) m_status = legal_status(inject.mstatus);
      if (inject.mip_en)     m_ip = inject.mip & IRQ_BITS;
      if (inject.mcause_en)  m_cause = inject.mcause;
      if (inject.mepc_en)    m_epc = inject.mepc;
      if (inject.mtval_en)   m_tval = inject.mtval;
      m_cycle   = cy_next;
      m_instret = ir_next;
    end
  end

  always @(negedge CLK) begin : compare
    csr_word_t    exp_v;
    logic         exp_inv;
    logic [191:0] exp_state;
    if (nRST) begin
      model_read(req.addr, req.priv, req.op != CSR_NONE, exp_v, exp_inv);
      exp_state = {m_status, m_tvec, m_ie, m_ip, m_cause, m_epc};
      n_checks++;
      if (rdata !== exp_v) begin
        n_rdata++;
        $display("ERR %s: rdata at %h expected %h actual %h",
                 test_name(test_id), req.addr, exp_v, rdata);
      end
      if (invalid !== exp_inv) begin
        n_inv++;
        $display("ERR %s: invalid at %h expected %b actual %b",
                 test_name(test_id), req.addr, exp_inv, invalid);
      end
      if (trap_state !== exp_state) begin
        n_state++;
        $display("ERR %s: trap_state expected %h actual %h",
                 test_name(test_id), exp_state, trap_state);
      end
    end
  end

endmodule

// File: csr_file_assert.sv
// Concurrent checks on the CSR write strobes and reset behaviour
// Bound into the CSR file top, watching the decode outputs
`timescale 1ns/1ps

module decode_rule_checks
  import csr_types_pkg::*;
(
  input logic          CLK,
  input logic          nRST,
  input logic          invalid,
  input csr_wr_t       wr,
  input csr_word_t     mscratch,
  input counter_ctrl_t mcounteren,
  input counter_ctrl_t mcountinhibit,
  input dword_t        cycle
);

  int fail_count = 0;   // Read by the testbench top

  // An mcycleh write replaces the upper half and holds the lower one
  high_half_write: assert property (@(posedge CLK) disable iff (!nRST)
                                    wr.strobe.mcycleh |=>
                                      (cycle == {$past(wr.value), $past(cycle[31:0])}))
    else begin
      $error("mcycleh write did not replace exactly the upper half");
      fail_count++;
    end

  // A rejected access must not touch any register
  rejected_write_holds: assert property (@(posedge CLK) disable iff (!nRST)
                                         invalid |=> ($stable(mscratch) && $stable(mcounteren)
                                                      && $stable(mcountinhibit)))
    else begin
      $error("register changed after a rejected access");
      fail_count++;
    end

  low_in_reset: assert property (@(posedge CLK) !nRST |-> !invalid)
    else begin
      $error("invalid is high during reset");
      fail_count++;
    end

endmodule

bind csr_file decode_rule_checks u_checks (
  .CLK          (CLK),
  .nRST         (nRST),
  .invalid      (invalid),
  .wr           (wr),
  .mscratch     (mscratch),
  .mcounteren   (mcounteren),
  .mcountinhibit(mcountinhibit),
  .cycle        (cycle)
);

// File: csr_file.sv
// Machine-mode CSR file for an RV32 core with M and U modes
// One access per cycle, old value and invalid returned combinationally,
// legalised new value committed at the next edge
`timescale 1ns/1ps

module csr_file
  import csr_types_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic         CLK,
  input  logic         nRST,
  input  csr_req_t     req,
  input  trap_inject_t inject,
  input  logic         inst_ret,
  output csr_word_t    rdata,
  output logic         invalid,
  output trap_state_t  trap_state
);

  csr_wr_t       wr;
  logic          addr_invalid;
  csr_word_t     mscratch;
  csr_word_t     mtval;
  counter_ctrl_t mcounteren;
  counter_ctrl_t mcountinhibit;
  dword_t        cycle;
  dword_t        instret;

  csr_read_mux #(
    .HART_ID(HART_ID)
  ) u_read_mux (
    .req          (req),
    .state        (trap_state),
    .mscratch     (mscratch),
    .mtval        (mtval),
    .mcounteren   (mcounteren),
    .mcountinhibit(mcountinhibit),
    .cycle        (cycle),
    .instret      (instret),
    .rdata        (rdata),
    .addr_invalid (addr_invalid)
  );

  csr_access_decode u_decode (
    .req         (req),
    .old_val     (rdata),
    .addr_invalid(addr_invalid),
    .invalid     (invalid),
    .wr          (wr)
  );

  machine_csr_regs u_regs (
    .CLK          (CLK),
    .nRST         (nRST),
    .wr           (wr),
    .inject       (inject),
    .state        (trap_state),
    .mscratch     (mscratch),
    .mtval        (mtval),
    .mcounteren   (mcounteren),
    .mcountinhibit(mcountinhibit)
  );

  perf_counter u_cycle (
    .CLK    (CLK),
    .nRST   (nRST),
    .inhibit(mcountinhibit.cy),
    .incr   (1'b1),              // Every clock
    .wr_lo  (wr.strobe.mcycle),
    .wr_hi  (wr.strobe.mcycleh),
    .wr_val (wr.value),
    .count  (cycle)
  );

  perf_counter u_instret (
    .CLK    (CLK),
    .nRST   (nRST),
    .inhibit(mcountinhibit.ir),
    .incr   (inst_ret),
    .wr_lo  (wr.strobe.minstret),
    .wr_hi  (wr.strobe.minstreth),
    .wr_val (wr.value),
    .count  (instret)
  );

endmodule

// File: csr_read_mux.sv
// CSR read mux
// Returns the current value of the addressed CSR and flags unknown
// addresses and user counter reads locked out by mcounteren
`timescale 1ns/1ps

module csr_read_mux
  import csr_types_pkg::*, csr_addr_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  csr_req_t      req,
  input  trap_state_t   state,
  input  csr_word_t     mscratch,
  input  csr_word_t     mtval,
  input  counter_ctrl_t mcounteren,
  input  counter_ctrl_t mcountinhibit,
  input  dword_t        cycle,
  input  dword_t        instret,
  output csr_word_t     rdata,
  output logic          addr_invalid
);

  logic user_lock_cy;
  logic user_lock_ir;

  assign user_lock_cy = (req.priv == U_MODE) && !mcounteren.cy;
  assign user_lock_ir = (req.priv == U_MODE) && !mcounteren.ir;

  always_comb begin
    rdata        = '0;
    addr_invalid = 1'b0;
    case (req.addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR,
      MCONFIGPTR_ADDR, MSTATUSH_ADDR: rdata = '0;   // Hardwired zero
      MHARTID_ADDR:       rdata = csr_word_t'(HART_ID);
      MISA_ADDR:          rdata = MISA_VALUE;
      MSTATUS_ADDR:       rdata = state.mstatus;
      MTVEC_ADDR:         rdata = state.mtvec;
      MIE_ADDR:           rdata = state.mie;
      MIP_ADDR:           rdata = state.mip;
      MCAUSE_ADDR:        rdata = state.mcause;
      MEPC_ADDR:          rdata = state.mepc;
      MSCRATCH_ADDR:      rdata = mscratch;
      MTVAL_ADDR:         rdata = mtval;
      MCOUNTEREN_ADDR:    rdata = mcounteren;
      MCOUNTINHIBIT_ADDR: rdata = mcountinhibit;
      MCYCLE_ADDR:        rdata = cycle[31:0];
      MCYCLEH_ADDR:       rdata = cycle[63:32];
      MINSTRET_ADDR:      rdata = instret[31:0];
      MINSTRETH_ADDR:     rdata = instret[63:32];
      CYCLE_ADDR: begin
        addr_invalid = user_lock_cy;
        rdata        = user_lock_cy ? '0 : cycle[31:0];
      end
      CYCLEH_ADDR: begin
        addr_invalid = user_lock_cy;
        rdata        = user_lock_cy ? '0 : cycle[63:32];
      end
      INSTRET_ADDR: begin
        addr_invalid = user_lock_ir;
        rdata        = user_lock_ir ? '0 : instret[31:0];
      end
      INSTRETH_ADDR: begin
        addr_invalid = user_lock_ir;
        rdata        = user_lock_ir ? '0 : instret[63:32];
      end
      default: addr_invalid = (req.op != CSR_NONE);  // Plain reads stay quiet
    endcase
  end

endmodule

// File: perf_counter.sv
// 64-bit performance counter
// Counts by incr unless inhibited, either 32-bit half can be overwritten
`timescale 1ns/1ps

module perf_counter
  import csr_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      inhibit,
  input  logic      incr,
  input  logic      wr_lo,
  input  logic      wr_hi,
  input  csr_word_t wr_val,
  output dword_t    count
);

  dword_t count_next;

  always_comb begin
    if (inhibit) begin
      count_next = count;
    end else begin
      count_next = count + dword_t'(incr);
    end
    // A half write replaces the increment for that cycle
    if (wr_lo) count_next = {count[63:32], wr_val};
    if (wr_hi) count_next = {wr_val, count[31:0]};
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

endmodule

// File: machine_csr_regs.sv
// Machine trap setup, trap handling and counter control registers
// Applies the legal-value rules on CSR writes, then lets trap
// injection from the trap controller override
`timescale 1ns/1ps

module machine_csr_regs
  import csr_types_pkg::*, csr_addr_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  input  csr_wr_t       wr,
  input  trap_inject_t  inject,
  output trap_state_t   state,
  output csr_word_t     mscratch,
  output csr_word_t     mtval,
  output counter_ctrl_t mcounteren,
  output counter_ctrl_t mcountinhibit
);

  mstatus_t      mstatus, mstatus_next;
  mtvec_t        mtvec, mtvec_next;
  mie_t          mie, mie_next;
  mip_t          mip, mip_next;
  mcause_t       mcause, mcause_next;
  csr_word_t     mepc, mepc_next;
  csr_word_t     mscratch_next, mtval_next;
  counter_ctrl_t mcounteren_next, mcountinhibit_next;

  // Keep only the implemented fields, S or reserved mpp falls back to U
  function automatic mstatus_t legal_mstatus(csr_word_t v);
    mstatus_t s;
    s      = '0;
    s.mie  = v[3];
    s.mpie = v[7];
    s.mprv = v[17];
    s.tw   = v[21];
    s.mpp  = (v[12:11] == M_MODE) ? M_MODE : U_MODE;
    return s;
  endfunction

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mcause_next        = mcause;
    mepc_next          = mepc;
    mscratch_next      = mscratch;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (wr.strobe.mstatus) mstatus_next = legal_mstatus(wr.value);
    if (wr.strobe.mtvec) begin
      mtvec_next.base = wr.value[31:2];
      mtvec_next.mode = (wr.value[1:0] > 2'b01) ? DIRECT : vec_mode_t'(wr.value[1:0]);
    end
    if (wr.strobe.mie)           mie_next           = mie_t'(wr.value & IRQ_MASK);
    if (wr.strobe.mip)           mip_next           = mip_t'(wr.value & IRQ_MASK);
    if (wr.strobe.mcause)        mcause_next        = mcause_t'(wr.value);
    if (wr.strobe.mepc)          mepc_next          = wr.value;
    if (wr.strobe.mscratch)      mscratch_next      = wr.value;
    if (wr.strobe.mtval)         mtval_next         = wr.value;
    if (wr.strobe.mcounteren)    mcounteren_next    = counter_ctrl_t'(wr.value);
    if (wr.strobe.mcountinhibit) mcountinhibit_next = counter_ctrl_t'(wr.value);

    // Trap controller wins over a same-cycle CSR write
    // Injected mstatus and mip still go through the field masks
    if (inject.mstatus_en) mstatus_next = legal_mstatus(inject.mstatus);
    if (inject.mip_en)     mip_next     = mip_t'(inject.mip & IRQ_MASK);
    if (inject.mcause_en)  mcause_next  = inject.mcause;
    if (inject.mepc_en)    mepc_next    = inject.mepc;
    if (inject.mtval_en)   mtval_next   = inject.mtval;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= mstatus_t'(MSTATUS_RESET);
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mcause        <= '0;
      mepc          <= '0;
      mscratch      <= '0;
      mtval         <= '0;
      mcounteren    <= counter_ctrl_t'(MCOUNTEREN_RESET);
      mcountinhibit <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mcause        <= mcause_next;
      mepc          <= mepc_next;
      mscratch      <= mscratch_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  assign state.mstatus = mstatus;
  assign state.mtvec   = mtvec;
  assign state.mie     = mie;
  assign state.mip     = mip;
  assign state.mcause  = mcause;
  assign state.mepc    = mepc;

endmodule

// File: csr_access_decode.sv
// CSR access decode
// Forms the new value for write, set and clear, checks privilege and
// read-only rules, and raises the write strobe of the addressed register
`timescale 1ns/1ps

module csr_access_decode
  import csr_types_pkg::*, csr_addr_pkg::*;
(
  input  csr_req_t  req,
  input  csr_word_t old_val,
  input  logic      addr_invalid,
  output logic      invalid,
  output csr_wr_t   wr
);

  logic      has_op;
  logic      priv_fault;
  csr_word_t new_val;

  assign has_op = (req.op != CSR_NONE);

  // Read-only space or not enough privilege
  assign priv_fault = has_op &&
                      ((req.addr[11:10] == 2'b11) || (req.addr[9:8] > req.priv));

  assign invalid = priv_fault | addr_invalid;

  always_comb begin
    case (req.op)
      CSR_SET:   new_val = old_val | req.wdata;
      CSR_CLEAR: new_val = old_val & ~req.wdata;
      default:   new_val = req.wdata;
    endcase
  end

  always_comb begin
    wr.strobe = '0;
    wr.value  = new_val;
    if (has_op && req.valid_write && !invalid) begin
      case (req.addr)
        MSTATUS_ADDR:       wr.strobe.mstatus       = 1'b1;
        MTVEC_ADDR:         wr.strobe.mtvec         = 1'b1;
        MIE_ADDR:           wr.strobe.mie           = 1'b1;
        MIP_ADDR:           wr.strobe.mip           = 1'b1;
        MSCRATCH_ADDR:      wr.strobe.mscratch      = 1'b1;
        MEPC_ADDR:          wr.strobe.mepc          = 1'b1;
        MCAUSE_ADDR:        wr.strobe.mcause        = 1'b1;
        MTVAL_ADDR:         wr.strobe.mtval         = 1'b1;
        MCOUNTEREN_ADDR:    wr.strobe.mcounteren    = 1'b1;
        MCOUNTINHIBIT_ADDR: wr.strobe.mcountinhibit = 1'b1;
        MCYCLE_ADDR:        wr.strobe.mcycle        = 1'b1;
        MCYCLEH_ADDR:       wr.strobe.mcycleh       = 1'b1;
        MINSTRET_ADDR:      wr.strobe.minstret      = 1'b1;
        MINSTRETH_ADDR:     wr.strobe.minstreth     = 1'b1;
        default:            wr.strobe               = '0;  // Info regs, misa, mstatush
      endcase
    end
  end

endmodule

// File: csr_addr_pkg.sv
// CSR address map for the machine-mode CSR file
// Also holds the misa constant and the register reset values
package csr_addr_pkg;

  // Machine information, read only
  localparam logic [11:0] MVENDORID_ADDR     = 12'hF11;
  localparam logic [11:0] MARCHID_ADDR       = 12'hF12;
  localparam logic [11:0] MIMPID_ADDR        = 12'hF13;
  localparam logic [11:0] MHARTID_ADDR       = 12'hF14;
  localparam logic [11:0] MCONFIGPTR_ADDR    = 12'hF15;

  // Trap setup
  localparam logic [11:0] MSTATUS_ADDR       = 12'h300;
  localparam logic [11:0] MISA_ADDR          = 12'h301;
  localparam logic [11:0] MIE_ADDR           = 12'h304;
  localparam logic [11:0] MTVEC_ADDR         = 12'h305;
  localparam logic [11:0] MCOUNTEREN_ADDR    = 12'h306;
  localparam logic [11:0] MSTATUSH_ADDR      = 12'h310;
  localparam logic [11:0] MCOUNTINHIBIT_ADDR = 12'h320;

  // Trap handling
  localparam logic [11:0] MSCRATCH_ADDR      = 12'h340;
  localparam logic [11:0] MEPC_ADDR          = 12'h341;
  localparam logic [11:0] MCAUSE_ADDR        = 12'h342;
  localparam logic [11:0] MTVAL_ADDR         = 12'h343;
  localparam logic [11:0] MIP_ADDR           = 12'h344;

  // Machine counters
  localparam logic [11:0] MCYCLE_ADDR        = 12'hB00;
  localparam logic [11:0] MINSTRET_ADDR      = 12'hB02;
  localparam logic [11:0] MCYCLEH_ADDR       = 12'hB80;
  localparam logic [11:0] MINSTRETH_ADDR     = 12'hB82;

  // User-level counter shadows
  localparam logic [11:0] CYCLE_ADDR         = 12'hC00;
  localparam logic [11:0] INSTRET_ADDR       = 12'hC02;
  localparam logic [11:0] CYCLEH_ADDR        = 12'hC80;
  localparam logic [11:0] INSTRETH_ADDR      = 12'hC82;

  // MXL = 1 (RV32), extensions I and U
  localparam logic [31:0] MISA_VALUE         = 32'h4010_0100;

  localparam logic [31:0] MSTATUS_RESET      = 32'h0020_0000;  // tw set, mpp U
  localparam logic [31:0] MCOUNTEREN_RESET   = 32'hFFFF_FFFF;

endpackage

// File: csr_types_pkg.sv
// CSR register formats for the machine-mode CSR file
// Field layouts, privilege and operation encodings, and the request,
// trap and write-bus structs shared by every block
package csr_types_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [63:0] dword_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vec_mode_t;

  // Software, timer and external interrupt bits
  localparam csr_word_t IRQ_MASK = 32'h0000_0888;

  typedef struct packed {
    logic [9:0]  reserved_3;
    logic        tw;          // bit 21
    logic [2:0]  reserved_2;
    logic        mprv;        // bit 17
    logic [3:0]  reserved_1;
    priv_level_t mpp;         // bits 12:11
    logic [2:0]  reserved_0;
    logic        mpie;        // bit 7
    logic [2:0]  reserved_p;
    logic        mie;         // bit 3
    logic [2:0]  reserved_l;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    vec_mode_t   mode;
  } mtvec_t;

  typedef struct packed {
    logic [19:0] reserved_2;
    logic        meie;
    logic [2:0]  reserved_1;
    logic        mtie;
    logic [2:0]  reserved_0;
    logic        msie;
    logic [2:0]  reserved_l;
  } mie_t;

  typedef struct packed {
    logic [19:0] reserved_2;
    logic        meip;
    logic [2:0]  reserved_1;
    logic        mtip;
    logic [2:0]  reserved_0;
    logic        msip;
    logic [2:0]  reserved_l;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] cause;
  } mcause_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] reserved;
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_ctrl_t;

  typedef struct packed {
    logic [11:0] addr;
    csr_op_t     op;
    csr_word_t   wdata;
    logic        valid_write;
    priv_level_t priv;
  } csr_req_t;

  // From the trap controller
  typedef struct packed {
    logic      mstatus_en;
    mstatus_t  mstatus;
    logic      mepc_en;
    csr_word_t mepc;
    logic      mcause_en;
    mcause_t   mcause;
    logic      mtval_en;
    csr_word_t mtval;
    logic      mip_en;
    mip_t      mip;
  } trap_inject_t;

  typedef struct packed {
    mstatus_t  mstatus;
    mtvec_t    mtvec;
    mie_t      mie;
    mip_t      mip;
    mcause_t   mcause;
    csr_word_t mepc;
  } trap_state_t;

  typedef struct packed {
    logic mstatus;
    logic mtvec;
    logic mie;
    logic mip;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mcounteren;
    logic mcountinhibit;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
  } csr_strobe_t;

  typedef struct packed {
    csr_strobe_t strobe;   // At most one set per cycle
    csr_word_t   value;
  } csr_wr_t;

endpackage
